//--- rtl/sdar_regs_pkg.sv
// SDAR register block definitions
// Bus widths, register map, reset defaults and constant words
// shared by the AXI4-Lite channel logic and the register bank

package sdar_regs_pkg;

    ////////////////////////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////////////////////////
    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 32;
    // One strobe bit per data byte
    localparam int axil_strb_w = axil_data_w / 8;

    // Incoming addresses are relocated by XOR with this base
    localparam logic [axil_addr_w-1:0] base_addr = 32'h4400_0000;

    ////////////////////////////////////////////////////////////
    // Register map, offsets after relocation
    ////////////////////////////////////////////////////////////
    localparam logic [axil_addr_w-1:0] reg_id_off      = 32'h0000_0000;
    localparam logic [axil_addr_w-1:0] reg_version_off = 32'h0000_0004;
    localparam logic [axil_addr_w-1:0] reg_flip_off    = 32'h0000_0008;
    localparam logic [axil_addr_w-1:0] reg_debug_off   = 32'h0000_000C;
    localparam logic [axil_addr_w-1:0] reg_result_off  = 32'h0000_0010;
    localparam logic [axil_addr_w-1:0] reg_pktin_off   = 32'h0000_0014;
    localparam logic [axil_addr_w-1:0] reg_pktout_off  = 32'h0000_0018;

    // Control register reset values
    localparam logic [axil_data_w-1:0] flip_default  = 32'h0000_0000;
    localparam logic [axil_data_w-1:0] debug_default = 32'h0000_0000;

    // Constant read words
    localparam logic [axil_data_w-1:0] block_id       = 32'h5DA1_0001;
    localparam logic [axil_data_w-1:0] block_version  = 32'h0001_0000;
    // Returned for any offset outside the map
    localparam logic [axil_data_w-1:0] unmapped_value = 32'hDEAD_BEEF;

    // AXI response code, only OKAY is ever returned
    localparam logic [1:0] resp_okay = 2'b00;

    // Channel controller states
    typedef enum logic [1:0] {
        idle,
        write_resp,
        read_data
    } axil_state_t;

endpackage

//--- rtl/reg_access_if.sv
// Register access interface
// Carries single-cycle write and read requests from the AXI4-Lite
// channel controller to the register bank, plus registered read data

`timescale 1ns/1ps

interface reg_access_if
    import sdar_regs_pkg::*;
();

    // Write request, valid while wr_en is high
    logic                   wr_en;
    logic [axil_addr_w-1:0] wr_addr;
    logic [axil_data_w-1:0] wr_data;
    logic [axil_strb_w-1:0] wr_strb;

    // Read request, data returns one cycle after rd_en
    logic                   rd_en;
    logic [axil_addr_w-1:0] rd_addr;
    logic [axil_data_w-1:0] rd_data;

    // Channel controller side
    modport ctrl (
        output wr_en, wr_addr, wr_data, wr_strb,
        output rd_en, rd_addr,
        input  rd_data
    );

    // Register bank side
    modport bank (
        input  wr_en, wr_addr, wr_data, wr_strb,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

//--- rtl/axil_channel_fsm.sv
// AXI4-Lite slave channel controller
// Accepts one write or read at a time, relocates the address against
// the block base and issues a single-cycle access to the register bank

`timescale 1ns/1ps

module axil_channel_fsm
    import sdar_regs_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    // Write address and data channels
    input  logic [axil_addr_w-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [axil_data_w-1:0] wdata,
    input  logic [axil_strb_w-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // Write response channel
    output logic                   bvalid,
    output logic [1:0]             bresp,
    input  logic                   bready,
    // Read address and data channels
    input  logic [axil_addr_w-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    output logic [axil_data_w-1:0] rdata,
    output logic [1:0]             rresp,
    input  logic                   rready,
    // Towards the register bank
    reg_access_if.ctrl             regs
);

    axil_state_t state;

    // Handshake registers
    logic wr_ready_q;
    logic rd_ready_q;
    logic bvalid_q;
    logic rvalid_q;

    // Captured request payload
    logic [axil_addr_w-1:0] wr_addr_q;
    logic [axil_data_w-1:0] wr_data_q;
    logic [axil_strb_w-1:0] wr_strb_q;
    logic [axil_addr_w-1:0] rd_addr_q;

    logic wr_start;
    logic rd_start;

    // Write needs address and data together
    assign wr_start = (state == idle) && awvalid && wvalid;
    // Write wins over a simultaneous read
    assign rd_start = (state == idle) && arvalid && !wr_start;

    ////////////////////////////////////////////////////////////
    // Channel state machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= idle;
            wr_ready_q <= 1'b0;
            rd_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            // Ready pulses last one cycle, one cycle after acceptance
            wr_ready_q <= wr_start;
            rd_ready_q <= rd_start;
            case (state)
                idle: begin
                    if (wr_start) begin
                        state <= write_resp;
                    end else if (rd_start) begin
                        state <= read_data;
                    end
                end
                write_resp: begin
                    // Register updates in the ready cycle, response follows
                    if (wr_ready_q) begin
                        bvalid_q <= 1'b1;
                    end else if (bvalid_q && bready) begin
                        bvalid_q <= 1'b0;
                        state    <= idle;
                    end
                end
                read_data: begin
                    // Bank data lands together with RVALID
                    if (rd_ready_q) begin
                        rvalid_q <= 1'b1;
                    end else if (rvalid_q && rready) begin
                        rvalid_q <= 1'b0;
                        state    <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Payload capture at acceptance
    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_start) begin
            wr_addr_q <= awaddr ^ base_addr;
            wr_data_q <= wdata;
            wr_strb_q <= wstrb;
        end
        if (rd_start) begin
            rd_addr_q <= araddr ^ base_addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////
    // One register drives both write readies
    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;
    assign bvalid  = bvalid_q;
    assign bresp   = resp_okay;
    assign arready = rd_ready_q;
    assign rvalid  = rvalid_q;
    // Bank holds rd_data until the next read
    assign rdata   = regs.rd_data;
    assign rresp   = resp_okay;

    // Single-cycle access strobes in the ready cycle
    assign regs.wr_en   = wr_ready_q;
    assign regs.wr_addr = wr_addr_q;
    assign regs.wr_data = wr_data_q;
    assign regs.wr_strb = wr_strb_q;
    assign regs.rd_en   = rd_ready_q;
    assign regs.rd_addr = rd_addr_q;

endmodule

//--- rtl/sdar_reg_bank.sv
// SDAR register bank
// Holds the flip and debug control registers, muxes the read word and
// turns reads of the live counters into delayed clear pulses

`timescale 1ns/1ps

module sdar_reg_bank
    import sdar_regs_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    // Live values from the core
    input  logic [axil_data_w-1:0] result_value,
    input  logic [axil_data_w-1:0] ip_flip,
    input  logic [axil_data_w-1:0] ip_debug,
    input  logic [axil_data_w-1:0] pktin_count,
    input  logic [axil_data_w-1:0] pktout_count,
    // Control values to the core
    output logic [axil_data_w-1:0] cpu_flip,
    output logic [axil_data_w-1:0] cpu_debug,
    // Clear-on-read pulses
    output logic                   result_clear,
    output logic                   pktin_clear,
    output logic                   pktout_clear,
    // From the channel controller
    reg_access_if.bank             regs
);

    logic [axil_data_w-1:0] rd_word;

    // Clear pipeline, bit 0 result, bit 1 pktin, bit 2 pktout
    logic [2:0] clr_hit;
    logic [2:0] clr_d1;
    logic [2:0] clr_q;

    // Byte lane merge under strobe
    function automatic logic [axil_data_w-1:0] merge_bytes(
        input logic [axil_data_w-1:0] old_val,
        input logic [axil_data_w-1:0] new_val,
        input logic [axil_strb_w-1:0] strb
    );
        logic [axil_data_w-1:0] result;
        result = old_val;
        for (int i = 0; i < axil_strb_w; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            cpu_flip  <= flip_default;
            cpu_debug <= debug_default;
        end else if (regs.wr_en) begin
            case (regs.wr_addr)
                reg_flip_off: begin
                    cpu_flip <= merge_bytes(cpu_flip, regs.wr_data, regs.wr_strb);
                end
                reg_debug_off: begin
                    cpu_debug <= merge_bytes(cpu_debug, regs.wr_data, regs.wr_strb);
                end
                default: begin
                    // Unmapped or read-only offset, write dropped
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (regs.rd_addr)
            reg_id_off:      rd_word = block_id;
            reg_version_off: rd_word = block_version;
            // Flip and debug read back what the core reports
            reg_flip_off:    rd_word = ip_flip;
            reg_debug_off:   rd_word = ip_debug;
            reg_result_off:  rd_word = result_value;
            reg_pktin_off:   rd_word = pktin_count;
            reg_pktout_off:  rd_word = pktout_count;
            default:         rd_word = unmapped_value;
        endcase
    end

    // Sampled once per read, held through RREADY back-pressure
    always_ff @(posedge S_AXI_ACLK) begin
        if (regs.rd_en) begin
            regs.rd_data <= rd_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Clear-on-read pipeline
    ////////////////////////////////////////////////////////////
    assign clr_hit[0] = regs.rd_en && (regs.rd_addr == reg_result_off);
    assign clr_hit[1] = regs.rd_en && (regs.rd_addr == reg_pktin_off);
    assign clr_hit[2] = regs.rd_en && (regs.rd_addr == reg_pktout_off);

    // Two stages, pulse lands two cycles after rd_en
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            clr_d1 <= 3'b000;
            clr_q  <= 3'b000;
        end else begin
            clr_d1 <= clr_hit;
            clr_q  <= clr_d1;
        end
    end

    assign result_clear = clr_q[0];
    assign pktin_clear  = clr_q[1];
    assign pktout_clear = clr_q[2];

endmodule

//--- rtl/sdar_cpu_regs.sv
// SDAR CPU register block top level
// AXI4-Lite slave with control, status and clear-on-read registers
// for the packet-processing core

`timescale 1ns/1ps

module sdar_cpu_regs
    import sdar_regs_pkg::*;
(
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    // AXI4-Lite slave
    input  logic [axil_addr_w-1:0] S_AXI_AWADDR,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    input  logic [axil_data_w-1:0] S_AXI_WDATA,
    input  logic [axil_strb_w-1:0] S_AXI_WSTRB,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,
    input  logic [axil_addr_w-1:0] S_AXI_ARADDR,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    output logic [axil_data_w-1:0] S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY,
    // Core side
    input  logic [axil_data_w-1:0] result_value,
    input  logic [axil_data_w-1:0] ip_flip,
    input  logic [axil_data_w-1:0] ip_debug,
    input  logic [axil_data_w-1:0] pktin_count,
    input  logic [axil_data_w-1:0] pktout_count,
    output logic [axil_data_w-1:0] cpu_flip,
    output logic [axil_data_w-1:0] cpu_debug,
    output logic                   result_clear,
    output logic                   pktin_clear,
    output logic                   pktout_clear
);

    // Decoded register requests
    reg_access_if regs_if ();

    // Bus handshakes to single-cycle accesses
    axil_channel_fsm axil_channel_fsm_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awaddr        (S_AXI_AWADDR),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bvalid        (S_AXI_BVALID),
        .bresp         (S_AXI_BRESP),
        .bready        (S_AXI_BREADY),
        .araddr        (S_AXI_ARADDR),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rvalid        (S_AXI_RVALID),
        .rdata         (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rready        (S_AXI_RREADY),
        .regs          (regs_if.ctrl)
    );

    // Registers and clear pulses
    sdar_reg_bank sdar_reg_bank_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .result_value  (result_value),
        .ip_flip       (ip_flip),
        .ip_debug      (ip_debug),
        .pktin_count   (pktin_count),
        .pktout_count  (pktout_count),
        .cpu_flip      (cpu_flip),
        .cpu_debug     (cpu_debug),
        .result_clear  (result_clear),
        .pktin_clear   (pktin_clear),
        .pktout_clear  (pktout_clear),
        .regs          (regs_if.bank)
    );

endmodule

//--- test/sdar_cpu_regs_checker.sv
// SDAR register block protocol checks
// Bound into the top level; response hold, clear pulse width
// and write ready pairing

`timescale 1ns/1ps

module sdar_cpu_regs_checker
    import sdar_regs_pkg::*;
(
    input logic                   S_AXI_ACLK,
    input logic                   S_AXI_ARESETN,
    input logic                   S_AXI_AWVALID,
    input logic                   S_AXI_WVALID,
    input logic                   S_AXI_AWREADY,
    input logic                   S_AXI_WREADY,
    input logic                   S_AXI_BVALID,
    input logic                   S_AXI_BREADY,
    input logic                   S_AXI_RVALID,
    input logic                   S_AXI_RREADY,
    input logic [axil_data_w-1:0] S_AXI_RDATA,
    input logic                   result_clear,
    input logic                   pktin_clear,
    input logic                   pktout_clear
);

    // Write response held until taken
    bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
        else $error("BVALID dropped before BREADY");

    // Read response and its data held until taken
    rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
        else $error("RVALID or RDATA changed before RREADY");

    // Clear pulses are single cycle
    result_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        result_clear |=> !result_clear)
        else $error("result_clear high for more than one cycle");
    pktin_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        pktin_clear |=> !pktin_clear)
        else $error("pktin_clear high for more than one cycle");
    pktout_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        pktout_clear |=> !pktout_clear)
        else $error("pktout_clear high for more than one cycle");

    // Write readies rise together, only after both valids
    write_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (S_AXI_AWREADY || S_AXI_WREADY) |->
            S_AXI_AWREADY && S_AXI_WREADY && $past(S_AXI_AWVALID && S_AXI_WVALID))
        else $error("AWREADY and WREADY not paired or not preceded by both valids");

endmodule

bind sdar_cpu_regs sdar_cpu_regs_checker sdar_cpu_regs_checker_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .result_clear  (result_clear),
    .pktin_clear   (pktin_clear),
    .pktout_clear  (pktout_clear)
);

//--- test/sdar_cpu_regs_tb.sv
// SDAR register block testbench
// Replays transactions from the vector file over AXI4-Lite with random
// response back-pressure, and checks read data, control registers and clear pulses

`timescale 1ns/1ps

module sdar_cpu_regs_tb
    import sdar_regs_pkg::*;
();

    // Eleven hex words per vector line
    localparam int vec_words   = 11;
    localparam int max_vectors = 40;

    logic                   S_AXI_ACLK;
    logic                   S_AXI_ARESETN;
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [axil_data_w-1:0] wdata;
    logic [axil_strb_w-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic [axil_data_w-1:0] result_value;
    logic [axil_data_w-1:0] ip_flip;
    logic [axil_data_w-1:0] ip_debug;
    logic [axil_data_w-1:0] pktin_count;
    logic [axil_data_w-1:0] pktout_count;
    logic [axil_data_w-1:0] cpu_flip;
    logic [axil_data_w-1:0] cpu_debug;
    logic                   result_clear;
    logic                   pktin_clear;
    logic                   pktout_clear;

    logic [31:0] vec_mem [0:511];
    int          num_vectors;
    int          responses = 0;
    int          errors;
    bit          vectors_ready = 1'b0;
    logic [31:0] lfsr;
    // Expected control register contents
    logic [31:0] model_flip;
    logic [31:0] model_debug;
    // Running totals of clear pulses
    int          result_pulses = 0;
    int          pktin_pulses  = 0;
    int          pktout_pulses = 0;
    // Previous VALID levels for response counting
    logic        bvalid_prev = 1'b0;
    logic        rvalid_prev = 1'b0;

    sdar_cpu_regs sdar_cpu_regs_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (wstrb),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .result_value  (result_value),
        .ip_flip       (ip_flip),
        .ip_debug      (ip_debug),
        .pktin_count   (pktin_count),
        .pktout_count  (pktout_count),
        .cpu_flip      (cpu_flip),
        .cpu_debug     (cpu_debug),
        .result_clear  (result_clear),
        .pktin_clear   (pktin_clear),
        .pktout_clear  (pktout_clear)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever begin
            #5 S_AXI_ACLK = ~S_AXI_ACLK;
        end
    end

    // Pulses last one cycle, so each is seen at exactly one falling edge
    always @(negedge S_AXI_ACLK) begin
        if (result_clear) begin
            result_pulses <= result_pulses + 1;
        end
        if (pktin_clear) begin
            pktin_pulses <= pktin_pulses + 1;
        end
        if (pktout_clear) begin
            pktout_pulses <= pktout_pulses + 1;
        end
    end

    // Each response counted once, when its VALID rises
    always @(negedge S_AXI_ACLK) begin
        bvalid_prev <= bvalid;
        rvalid_prev <= rvalid;
        if (bvalid && !bvalid_prev) begin
            responses <= responses + 1;
        end
        if (rvalid && !rvalid_prev) begin
            responses <= responses + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // Expected register value after a strobed write
    function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
                                                 input logic [31:0] new_val,
                                                 input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic [31:0] vec_word(input int vec, input int col);
        logic [8:0] pos;
        pos = 9'(vec * vec_words + col);
        return vec_mem[pos];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Ready delay of 0 to 3 cycles, two LFSR bits
    task automatic pick_delay(output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            cycles = cycles * 2 + int'(lfsr[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus transactions, entered and left on a falling edge
    ////////////////////////////////////////////////////////////
    task automatic bus_write(input logic [31:0] offset, input logic [31:0] data,
                             input logic [3:0] strb);
        int wait_cycles;
        awaddr  = base_addr | offset;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge S_AXI_ACLK);
        while (!awready) begin
            @(negedge S_AXI_ACLK);
        end
        check_value("S_AXI_WREADY", {31'b0, wready}, 32'd1);
        // Handshake edge passes here
        @(negedge S_AXI_ACLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            @(negedge S_AXI_ACLK);
        end
        if (offset == reg_flip_off) begin
            model_flip = apply_strobe(model_flip, data, strb);
        end else if (offset == reg_debug_off) begin
            model_debug = apply_strobe(model_debug, data, strb);
        end
        check_value("cpu_flip", cpu_flip, model_flip);
        check_value("cpu_debug", cpu_debug, model_debug);
        check_value("S_AXI_BRESP", {30'b0, bresp}, {30'b0, resp_okay});
        pick_delay(wait_cycles);
        repeat (wait_cycles) @(negedge S_AXI_ACLK);
        bready = 1'b1;
        @(negedge S_AXI_ACLK);
        bready = 1'b0;
        check_value("S_AXI_BVALID", {31'b0, bvalid}, 32'd0);
    endtask

    task automatic bus_read(input logic [31:0] offset, output logic [31:0] data);
        int wait_cycles;
        araddr  = base_addr | offset;
        arvalid = 1'b1;
        @(negedge S_AXI_ACLK);
        while (!arready) begin
            @(negedge S_AXI_ACLK);
        end
        @(negedge S_AXI_ACLK);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge S_AXI_ACLK);
        end
        pick_delay(wait_cycles);
        repeat (wait_cycles) @(negedge S_AXI_ACLK);
        // Sampled after the stall, so held data is what gets checked
        data = rdata;
        check_value("S_AXI_RRESP", {30'b0, rresp}, {30'b0, resp_okay});
        rready = 1'b1;
        @(negedge S_AXI_ACLK);
        rready = 1'b0;
        check_value("S_AXI_RVALID", {31'b0, rvalid}, 32'd0);
    endtask

    task automatic run_vector(input int idx);
        logic [31:0] op;
        logic [31:0] offset;
        logic [31:0] exp_clr;
        logic [31:0] rd_val;
        int          res_before;
        int          in_before;
        int          out_before;
        op           = vec_word(idx, 0);
        offset       = vec_word(idx, 1);
        result_value = vec_word(idx, 4);
        ip_flip      = vec_word(idx, 5);
        ip_debug     = vec_word(idx, 6);
        pktin_count  = vec_word(idx, 7);
        pktout_count = vec_word(idx, 8);
        exp_clr      = vec_word(idx, 10);
        res_before   = result_pulses;
        in_before    = pktin_pulses;
        out_before   = pktout_pulses;
        if (op == 32'd1) begin
            bus_write(offset, vec_word(idx, 2), 4'(vec_word(idx, 3)));
        end else begin
            bus_read(offset, rd_val);
            check_value("S_AXI_RDATA", rd_val, vec_word(idx, 9));
        end
        // Clear pulse trails RVALID by one cycle
        repeat (2) @(negedge S_AXI_ACLK);
        check_value("result_clear pulses", result_pulses - res_before, {31'b0, exp_clr[0]});
        check_value("pktin_clear pulses", pktin_pulses - in_before, {31'b0, exp_clr[1]});
        check_value("pktout_clear pulses", pktout_pulses - out_before, {31'b0, exp_clr[2]});
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        S_AXI_ARESETN = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        result_value  = '0;
        ip_flip       = '0;
        ip_debug      = '0;
        pktin_count   = '0;
        pktout_count  = '0;
        errors        = 0;
        lfsr          = 32'h71d1;
        model_flip    = flip_default;
        model_debug   = debug_default;
        $readmemh("test/sdar_regs_vectors.txt", vec_mem);
        // Op 1 write, op 2 read, anything else ends the list
        num_vectors = 0;
        while (num_vectors < max_vectors &&
               (vec_word(num_vectors, 0) == 32'd1 || vec_word(num_vectors, 0) == 32'd2)) begin
            num_vectors = num_vectors + 1;
        end
        vectors_ready = 1'b1;
        repeat (2) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);
        check_value("S_AXI_AWREADY", {31'b0, awready}, 32'd0);
        check_value("S_AXI_WREADY", {31'b0, wready}, 32'd0);
        check_value("S_AXI_BVALID", {31'b0, bvalid}, 32'd0);
        check_value("S_AXI_ARREADY", {31'b0, arready}, 32'd0);
        check_value("S_AXI_RVALID", {31'b0, rvalid}, 32'd0);
        check_value("clear outputs", {29'b0, pktout_clear, pktin_clear, result_clear}, 32'd0);
        check_value("cpu_flip", cpu_flip, flip_default);
        check_value("cpu_debug", cpu_debug, debug_default);
        if (num_vectors == 0) begin
            errors = errors + 1;
            $display("No vectors could be loaded from the vector file");
        end
        for (int i = 0; i < num_vectors; i++) begin
            run_vector(i);
        end
        check_value("response count", responses, num_vectors);
        $display("Done: %0d errors, %0d responses for %0d vectors", errors, responses,
                 num_vectors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Worst case per vector is well under 50 cycles
    initial begin
        wait (vectors_ready);
        repeat (num_vectors * 50 + 200) @(posedge S_AXI_ACLK);
        $display("Timeout: the transactions did not complete in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- test/sdar_regs_vectors.txt
// op offset wdata wstrb result ip_flip ip_debug pktin pktout exp_rdata exp_clear
// op 1 write, 2 read, 0 ends the list; exp_clear bit 0 result, bit 1 pktin, bit 2 pktout
2 00 00000000 0 00000001 00000002 00000003 00000004 00000005 5DA10001 0
2 04 00000000 0 00000001 00000002 00000003 00000004 00000005 00010000 0
1 08 A5A5A5A5 F 00000000 00000000 00000000 00000000 00000000 00000000 0
1 0C 12345678 3 00000000 00000000 00000000 00000000 00000000 00000000 0
1 08 0000FF00 2 00000000 00000000 00000000 00000000 00000000 00000000 0
1 0C CAFEBABE C 00000000 00000000 00000000 00000000 00000000 00000000 0
2 08 00000000 0 0000002A 11112222 33334444 00000100 00000200 11112222 0
2 0C 00000000 0 0000002A 11112222 33334444 00000100 00000200 33334444 0
2 10 00000000 0 0000002A 11112222 33334444 00000100 00000200 0000002A 1
2 14 00000000 0 0000002A 11112222 33334444 00000100 00000200 00000100 2
2 18 00000000 0 0000002A 11112222 33334444 00000100 00000200 00000200 4
2 1C 00000000 0 0000002A 11112222 33334444 00000100 00000200 DEADBEEF 0
1 20 FFFFFFFF F 00000000 00000000 00000000 00000000 00000000 00000000 0
2 FC 00000000 0 0000002A 11112222 33334444 00000100 00000200 DEADBEEF 0
1 08 12345678 0 00000000 00000000 00000000 00000000 00000000 00000000 0
2 10 00000000 0 7FFFFFFF 55556666 77778888 00000101 00000201 7FFFFFFF 1
1 0C 00000000 1 00000000 00000000 00000000 00000000 00000000 00000000 0
2 14 00000000 0 7FFFFFFF 55556666 77778888 00000101 00000201 00000101 2
2 18 00000000 0 7FFFFFFF 55556666 77778888 00000101 FFFFFFFF FFFFFFFF 4
2 08 00000000 0 7FFFFFFF 0BADF00D 77778888 00000101 00000201 0BADF00D 0
0

//--- src.f
rtl/sdar_regs_pkg.sv
rtl/reg_access_if.sv
rtl/axil_channel_fsm.sv
rtl/sdar_reg_bank.sv
rtl/sdar_cpu_regs.sv
test/sdar_cpu_regs_checker.sv
test/sdar_cpu_regs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SDAR register block testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module sdar_cpu_regs_tb \
    -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsdar_cpu_regs_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
